/* source/vecu_settings.svh */
// Lane count, register count, element width and vector length macros

`ifndef VECU_SETTINGS_SVH
`define VECU_SETTINGS_SVH

// Number of parallel lanes
`define VECU_NR_LANES 4

// Architectural vector registers
`define VECU_NR_VREGS 8

// Element width in bits
`define VECU_ELEM_W 32

// Elements per vector register
`define VECU_VLEN_ELEMS 16

// Elements held by each lane per register
`define VECU_SLOTS (`VECU_VLEN_ELEMS / `VECU_NR_LANES)

`endif

/* source/vecu_pkg.sv */
// Opcode and ALU enums, request, decoded request, lane command and finish structs

`include "vecu_settings.svh"

package vecu_pkg;

  localparam int unsigned LANE_W     = (`VECU_NR_LANES > 1) ? $clog2(`VECU_NR_LANES) : 1;
  localparam int unsigned SLOT_W     = (`VECU_SLOTS > 1) ? $clog2(`VECU_SLOTS) : 1;
  localparam int unsigned ELEM_IDX_W = $clog2(`VECU_VLEN_ELEMS);

  typedef logic [2:0]              vreg_idx_t;
  typedef logic [`VECU_ELEM_W-1:0] elem_t;
  typedef logic [SLOT_W-1:0]       slot_idx_t;
  typedef logic [LANE_W-1:0]       lane_idx_t;

  // Host opcodes
  typedef enum logic [3:0] {
    OP_VADD    = 4'd0,
    OP_VSUB    = 4'd1,
    OP_VAND    = 4'd2,
    OP_VOR     = 4'd3,
    OP_VXOR    = 4'd4,
    OP_VADDX   = 4'd5,
    OP_VMVX    = 4'd6,
    OP_VREDSUM = 4'd7,
    OP_VEXT    = 4'd8
  } vecu_opcode_e;

  // Lane ALU functions
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_ADDS = 3'd5,
    ALU_MOVS = 3'd6
  } alu_op_e;

  typedef enum logic [1:0] {
    FIN_NONE    = 2'd0,
    FIN_REDUCE  = 2'd1,
    FIN_EXTRACT = 2'd2
  } finish_kind_e;

  typedef enum logic [1:0] {
    PART_HOLD = 2'd0,
    PART_LOAD = 2'd1,
    PART_ACC  = 2'd2
  } partial_act_e;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // For OP_VEXT the low scalar bits carry the element index
  typedef struct packed {
    vecu_opcode_e opcode;
    vreg_idx_t    vd;
    vreg_idx_t    vs1;
    vreg_idx_t    vs2;
    elem_t        scalar;
  } vecu_req_t;

  typedef struct packed {
    alu_op_e      alu_op;
    vreg_idx_t    vd;
    vreg_idx_t    vs1;
    vreg_idx_t    vs2;
    elem_t        scalar;
    logic         write;
    finish_kind_e kind;
    slot_idx_t    ext_slot;
    lane_idx_t    ext_lane;
  } decoded_req_t;

  // One cycle of work, broadcast to every lane
  typedef struct packed {
    logic         valid;
    alu_op_e      alu_op;
    vreg_idx_t    vd;
    vreg_idx_t    vs1;
    vreg_idx_t    vs2;
    slot_idx_t    slot;
    elem_t        scalar;
    logic         write;
    partial_act_e partial_act;
  } lane_cmd_t;

  typedef struct packed {
    logic         valid;
    finish_kind_e kind;
    lane_idx_t    lane;
  } finish_t;

endpackage : vecu_pkg

/* source/vecu_dispatcher.sv */
// Host request decode, busy tracking and scalar response register

`include "vecu_settings.svh"

module vecu_dispatcher (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Host side
  input  logic                   req_valid_i,
  input  vecu_pkg::vecu_req_t    req_i,
  output logic                   busy_o,
  output logic                   resp_valid_o,
  output vecu_pkg::elem_t        resp_data_o,
  // Sequencer side
  output logic                   start_o,
  output vecu_pkg::decoded_req_t dec_o,
  input  logic                   done_i,
  // Reduction unit side
  input  logic                   resp_valid_i,
  input  vecu_pkg::elem_t        resp_data_i
);

  import vecu_pkg::*;

  logic                  accept;
  logic                  busy_q;
  logic                  start_q;
  logic                  resp_valid_q;
  elem_t                 resp_data_q;
  decoded_req_t          dec_d;
  decoded_req_t          dec_q;
  logic [ELEM_IDX_W-1:0] elem_idx;

  // Requests seen while busy are dropped
  assign accept = req_valid_i & ~busy_q;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    elem_idx       = req_i.scalar[ELEM_IDX_W-1:0];
    dec_d.vd       = req_i.vd;
    dec_d.vs1      = req_i.vs1;
    dec_d.vs2      = req_i.vs2;
    dec_d.scalar   = req_i.scalar;
    // Element i sits in lane i mod lanes, slot i div lanes
    dec_d.ext_lane = lane_idx_t'(elem_idx % `VECU_NR_LANES);
    dec_d.ext_slot = slot_idx_t'(elem_idx / `VECU_NR_LANES);
    dec_d.alu_op   = ALU_ADD;
    dec_d.write    = 1'b1;
    dec_d.kind     = FIN_NONE;
    case (req_i.opcode)
      OP_VADD:  dec_d.alu_op = ALU_ADD;
      OP_VSUB:  dec_d.alu_op = ALU_SUB;
      OP_VAND:  dec_d.alu_op = ALU_AND;
      OP_VOR:   dec_d.alu_op = ALU_OR;
      OP_VXOR:  dec_d.alu_op = ALU_XOR;
      OP_VADDX: dec_d.alu_op = ALU_ADDS;
      OP_VMVX:  dec_d.alu_op = ALU_MOVS;
      OP_VREDSUM: begin
        dec_d.write = 1'b0;
        dec_d.kind  = FIN_REDUCE;
      end
      OP_VEXT: begin
        dec_d.write = 1'b0;
        dec_d.kind  = FIN_EXTRACT;
      end
      // Unknown opcodes run through the slots without effect
      default: dec_d.write = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_q <= dec_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Busy and response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      start_q      <= 1'b0;
      resp_valid_q <= 1'b0;
      resp_data_q  <= '0;
    end else begin
      start_q      <= accept;
      resp_valid_q <= resp_valid_i;
      if (resp_valid_i) begin
        resp_data_q <= resp_data_i;
      end
      // Write-only ops end on done, scalar ops once the host saw the answer
      if (accept) begin
        busy_q <= 1'b1;
      end else if ((done_i && dec_q.kind == FIN_NONE) || resp_valid_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign start_o      = start_q;
  assign dec_o        = dec_q;
  assign busy_o       = busy_q;
  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;

endmodule : vecu_dispatcher

/* source/vecu_sequencer.sv */
// Slot sequencer issuing per-cycle lane commands and the finish request

`include "vecu_settings.svh"

module vecu_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  input  vecu_pkg::decoded_req_t dec_i,
  output vecu_pkg::lane_cmd_t    cmd_o,
  output vecu_pkg::finish_t      fin_o,
  output logic                   done_o
);

  import vecu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_FINISH
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  slot_idx_t  slot_q;
  slot_idx_t  slot;
  logic       active;
  logic       last;

  // Slot 0 goes out in the start cycle itself
  assign active = (state_q == S_RUN) || (state_q == S_IDLE && start_i);
  assign slot   = (state_q == S_RUN) ? slot_q : '0;
  assign last   = (slot == slot_idx_t'(`VECU_SLOTS - 1));

  // The decoded request stays stable in the dispatcher while busy
  always_comb begin
    cmd_o.valid       = active;
    cmd_o.alu_op      = dec_i.alu_op;
    cmd_o.vd          = dec_i.vd;
    cmd_o.vs1         = dec_i.vs1;
    cmd_o.vs2         = dec_i.vs2;
    cmd_o.slot        = slot;
    cmd_o.scalar      = dec_i.scalar;
    cmd_o.write       = dec_i.write;
    cmd_o.partial_act = PART_HOLD;
    case (dec_i.kind)
      FIN_REDUCE:  cmd_o.partial_act = (slot == '0) ? PART_LOAD : PART_ACC;
      FIN_EXTRACT: cmd_o.partial_act = (slot == dec_i.ext_slot) ? PART_LOAD : PART_HOLD;
      default:     cmd_o.partial_act = PART_HOLD;
    endcase
  end

  always_comb begin
    state_d = state_q;
    if (active) begin
      if (!last) begin
        state_d = S_RUN;
      end else if (dec_i.kind == FIN_NONE) begin
        state_d = S_IDLE;
      end else begin
        state_d = S_FINISH;
      end
    end else if (state_q == S_FINISH) begin
      state_d = S_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      slot_q  <= '0;
    end else begin
      state_q <= state_d;
      if (active) begin
        slot_q <= slot_idx_t'(slot + 1'b1);
      end
    end
  end

  assign fin_o.valid = (state_q == S_FINISH);
  assign fin_o.kind  = dec_i.kind;
  assign fin_o.lane  = dec_i.ext_lane;

  assign done_o = (active && last && dec_i.kind == FIN_NONE) || (state_q == S_FINISH);

endmodule : vecu_sequencer

/* source/vecu_lane.sv */
// Lane with its register file slice, element ALU and partial-result register

`include "vecu_settings.svh"

module vecu_lane (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  vecu_pkg::lane_cmd_t cmd_i,
  output vecu_pkg::elem_t     partial_o
);

  import vecu_pkg::*;

  // Element at slot s of register r
  elem_t vrf_q [`VECU_NR_VREGS][`VECU_SLOTS];
  elem_t op_a;
  elem_t op_b;
  elem_t alu_res;
  elem_t partial_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operand read and ALU
  ////////////////////////////////////////////////////////////////////////////

  assign op_a = vrf_q[cmd_i.vs1][cmd_i.slot];
  assign op_b = vrf_q[cmd_i.vs2][cmd_i.slot];

  always_comb begin
    case (cmd_i.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      // vs1 minus vs2
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_ADDS: alu_res = op_a + cmd_i.scalar;
      ALU_MOVS: alu_res = cmd_i.scalar;
      default:  alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vrf_q <= '{default: '0};
    end else if (cmd_i.valid && cmd_i.write) begin
      vrf_q[cmd_i.vd][cmd_i.slot] <= alu_res;
    end
  end

  // Partial sum or picked element, fed from vs1
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      partial_q <= '0;
    end else if (cmd_i.valid) begin
      case (cmd_i.partial_act)
        PART_LOAD: partial_q <= op_a;
        PART_ACC:  partial_q <= partial_q + op_a;
        default:   partial_q <= partial_q;
      endcase
    end
  end

  assign partial_o = partial_q;

endmodule : vecu_lane

/* source/vecu_reduction_unit.sv */
// Cross-lane combiner producing the scalar response

`include "vecu_settings.svh"

module vecu_reduction_unit (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  vecu_pkg::finish_t                     fin_i,
  input  vecu_pkg::elem_t [`VECU_NR_LANES-1:0]  partial_i,
  output logic                                  resp_valid_o,
  output vecu_pkg::elem_t                       resp_data_o
);

  import vecu_pkg::*;

  elem_t lane_sum;
  elem_t selected;
  elem_t result;
  logic  resp_valid_q;
  elem_t resp_data_q;

  // Adder tree over all lanes, wraps at the element width
  always_comb begin
    lane_sum = '0;
    for (int l = 0; l < `VECU_NR_LANES; l++) begin
      lane_sum = lane_sum + partial_i[l];
    end
  end

  assign selected = partial_i[fin_i.lane];
  assign result   = (fin_i.kind == FIN_REDUCE) ? lane_sum : selected;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
      resp_data_q  <= '0;
    end else begin
      resp_valid_q <= fin_i.valid;
      if (fin_i.valid) begin
        resp_data_q <= result;
      end
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;

endmodule : vecu_reduction_unit

/* source/vecu_top.sv */
// Coprocessor top level with dispatcher, sequencer, lanes and reduction unit

`include "vecu_settings.svh"

module vecu_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  input  vecu_pkg::vecu_req_t req_i,
  output logic                busy_o,
  output logic                resp_valid_o,
  output vecu_pkg::elem_t     resp_data_o
);

  import vecu_pkg::*;

  // Dispatcher to sequencer
  logic         start;
  decoded_req_t dec;
  logic         done;
  // Sequencer to lanes and reduction unit
  lane_cmd_t    cmd;
  finish_t      fin;
  // Reduction unit back to dispatcher
  logic         red_valid;
  elem_t        red_data;

  elem_t [`VECU_NR_LANES-1:0] partial;

  vecu_dispatcher i_dispatcher (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_i        (req_i       ),
    .busy_o       (busy_o      ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o ),
    .start_o      (start       ),
    .dec_o        (dec         ),
    .done_i       (done        ),
    .resp_valid_i (red_valid   ),
    .resp_data_i  (red_data    )
  );

  vecu_sequencer i_sequencer (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .start_i (start  ),
    .dec_i   (dec    ),
    .cmd_o   (cmd    ),
    .fin_o   (fin    ),
    .done_o  (done   )
  );

  for (genvar g = 0; g < `VECU_NR_LANES; g++) begin : gen_lanes
    vecu_lane i_lane (
      .clk_i     (clk_i     ),
      .rst_n_i   (rst_n_i   ),
      .cmd_i     (cmd       ),
      .partial_o (partial[g])
    );
  end : gen_lanes

  vecu_reduction_unit i_reduction_unit (
    .clk_i        (clk_i    ),
    .rst_n_i      (rst_n_i  ),
    .fin_i        (fin      ),
    .partial_i    (partial  ),
    .resp_valid_o (red_valid),
    .resp_data_o  (red_data )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Elaboration checks
  ////////////////////////////////////////////////////////////////////////////

  if (`VECU_NR_LANES == 0) begin : gen_chk_zero
    $error("[vecu] At least one lane is required");
  end else if ((`VECU_NR_LANES & (`VECU_NR_LANES - 1)) != 0) begin : gen_chk_pow2
    $error("[vecu] Lane count must be a power of two");
  end else if ((`VECU_VLEN_ELEMS % `VECU_NR_LANES) != 0) begin : gen_chk_div
    $error("[vecu] Lane count must divide the vector length");
  end

endmodule : vecu_top

/* bench/vecu_tb_clock.sv */
// Clock and reset generator for the vecu testbench

module vecu_tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule : vecu_tb_clock

/* bench/vecu_assertions.sv */
// Concurrent assertions on the dispatcher handshake and their bind

module vecu_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic busy_i,
  input logic resp_valid_i
);

  int unsigned fail_cnt = 0;

  // Response strobe lasts one cycle
  single_cycle_resp : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) resp_valid_i |=> !resp_valid_i
  ) else begin
    fail_cnt++;
    $error("resp_valid_o high for two consecutive cycles");
  end

  resp_only_while_busy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) resp_valid_i |-> busy_i
  ) else begin
    fail_cnt++;
    $error("resp_valid_o high while busy_o is low");
  end

  // First cycle out of reset
  idle_after_reset : assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> !busy_i
  ) else begin
    fail_cnt++;
    $error("busy_o high in the first cycle after reset");
  end

endmodule : vecu_assertions

bind vecu_dispatcher vecu_assertions i_assertions (
  .clk_i        (clk_i       ),
  .rst_n_i      (rst_n_i     ),
  .busy_i       (busy_o      ),
  .resp_valid_i (resp_valid_o)
);

/* bench/vecu_tb.sv */
// Testbench top with stimulus, reference model, response checker and watchdog

`include "vecu_settings.svh"

module vecu_tb;

  import vecu_pkg::*;

  localparam int N_RAND  = 40;
  localparam int N_RED   = 8;
  localparam int N_BUSY  = 4;
  // Ignored requests are counted too
  localparam int N_INSTR = 2 + 8 + 8 * 16 + 8 + 2 * N_RAND + 2 * N_RED + 5 * N_BUSY;
  localparam int RESP_DELAY = `VECU_SLOTS + 2;

  typedef struct packed {
    elem_t       data;
    logic [31:0] accept_cyc;
  } exp_resp_t;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  vecu_req_t   req;
  logic        busy;
  logic        resp_valid;
  elem_t       resp_data;

  logic [31:0] cycle_cnt = '0;
  logic [31:0] lfsr_state = 32'h8caf_fc04;
  int unsigned mismatch_errs = 0;
  int unsigned timing_errs = 0;
  int unsigned protocol_errs = 0;
  exp_resp_t   exp_q [$];
  elem_t       ref_vrf [`VECU_NR_VREGS][`VECU_VLEN_ELEMS];

  vecu_tb_clock #(.PERIOD(8), .RESET_CYCLES(2)) i_clock (
    .clk_o   (clk  ),
    .rst_n_o (rst_n)
  );

  vecu_top i_vecu_top (
    .clk_i        (clk       ),
    .rst_n_i      (rst_n     ),
    .req_valid_i  (req_valid ),
    .req_i        (req       ),
    .busy_o       (busy      ),
    .resp_valid_o (resp_valid),
    .resp_data_o  (resp_data )
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic vecu_opcode_e pick_arith_op(input logic [31:0] idx);
    case (idx % 6)
      0:       return OP_VADD;
      1:       return OP_VSUB;
      2:       return OP_VAND;
      3:       return OP_VOR;
      4:       return OP_VXOR;
      default: return OP_VADDX;
    endcase
  endfunction

  function automatic vecu_req_t make_req(input vecu_opcode_e op, input vreg_idx_t vd,
                                         input vreg_idx_t vs1, input vreg_idx_t vs2,
                                         input elem_t scalar);
    vecu_req_t r;
    r.opcode = op;
    r.vd     = vd;
    r.vs1    = vs1;
    r.vs2    = vs2;
    r.scalar = scalar;
    return r;
  endfunction

  // Updates the model registers and returns any scalar answer
  function automatic elem_t model_apply(input vecu_req_t r);
    elem_t res;
    res = '0;
    for (int i = 0; i < `VECU_VLEN_ELEMS; i++) begin
      case (r.opcode)
        OP_VADD:    ref_vrf[r.vd][i] = ref_vrf[r.vs1][i] + ref_vrf[r.vs2][i];
        OP_VSUB:    ref_vrf[r.vd][i] = ref_vrf[r.vs1][i] - ref_vrf[r.vs2][i];
        OP_VAND:    ref_vrf[r.vd][i] = ref_vrf[r.vs1][i] & ref_vrf[r.vs2][i];
        OP_VOR:     ref_vrf[r.vd][i] = ref_vrf[r.vs1][i] | ref_vrf[r.vs2][i];
        OP_VXOR:    ref_vrf[r.vd][i] = ref_vrf[r.vs1][i] ^ ref_vrf[r.vs2][i];
        OP_VADDX:   ref_vrf[r.vd][i] = ref_vrf[r.vs1][i] + r.scalar;
        OP_VMVX:    ref_vrf[r.vd][i] = r.scalar;
        OP_VREDSUM: res = res + ref_vrf[r.vs1][i];
        default:    ;
      endcase
    end
    if (r.opcode == OP_VEXT) begin
      res = ref_vrf[r.vs1][r.scalar % `VECU_VLEN_ELEMS];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Request driver
  ////////////////////////////////////////////////////////////////////////////

  // Called on a falling edge and optionally holds a second request while busy
  task automatic issue(input vecu_req_t r, input bit with_extra = 1'b0,
                       input vecu_req_t extra = '0);
    elem_t     res;
    exp_resp_t e;
    req_valid = 1'b1;
    req       = r;
    @(negedge clk);
    assert (busy) else begin
      protocol_errs++;
      $display("Request was not accepted, busy_o stayed low");
    end
    res = model_apply(r);
    if (r.opcode == OP_VREDSUM || r.opcode == OP_VEXT) begin
      e.data       = res;
      e.accept_cyc = cycle_cnt;
      exp_q.push_back(e);
    end
    if (with_extra) begin
      req = extra;
      @(negedge clk);
    end
    req_valid = 1'b0;
    while (busy) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response checker
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    exp_resp_t e;
    if (rst_n && resp_valid) begin
      assert (exp_q.size() != 0) else begin
        protocol_errs++;
        $display("Response appeared with no instruction waiting for one");
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (resp_data == e.data) else begin
          mismatch_errs++;
          $display("MISMATCH resp_data_o: got %08h expected %08h", resp_data, e.data);
        end
        assert (cycle_cnt - e.accept_cyc == RESP_DELAY) else begin
          timing_errs++;
          $display("Response came %0d edges after acceptance instead of %0d",
                   cycle_cnt - e.accept_cyc, RESP_DELAY);
        end
      end
    end
  end

  // Watchdog
  initial begin
    repeat (40 * N_INSTR + 100) @(posedge clk);
    $display("Timeout, the run did not complete within %0d cycles", 40 * N_INSTR + 100);
    $display("Errors: mismatch %0d, timing %0d, protocol %0d", mismatch_errs,
             timing_errs, protocol_errs);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    vreg_idx_t   a;
    vreg_idx_t   b;
    elem_t       v;
    int unsigned total;
    req_valid = 1'b0;
    req       = '0;
    for (int r = 0; r < `VECU_NR_VREGS; r++) begin
      for (int i = 0; i < `VECU_VLEN_ELEMS; i++) begin
        ref_vrf[r][i] = '0;
      end
    end
    @(posedge rst_n);
    @(negedge clk);

    // Registers read zero after reset
    issue(make_req(OP_VEXT, 0, 5, 0, 7));
    issue(make_req(OP_VREDSUM, 0, 6, 0, 0));

    // Broadcast then extract every element
    for (int r = 0; r < `VECU_NR_VREGS; r++) begin
      issue(make_req(OP_VMVX, vreg_idx_t'(r), 0, 0, rand_bits(32)));
    end
    for (int r = 0; r < `VECU_NR_VREGS; r++) begin
      for (int i = 0; i < `VECU_VLEN_ELEMS; i++) begin
        issue(make_req(OP_VEXT, 0, vreg_idx_t'(r), 0, i));
      end
    end

    // Wraparound on add and subtract
    issue(make_req(OP_VMVX, 0, 0, 0, 32'hffff_fffe));
    issue(make_req(OP_VMVX, 1, 0, 0, 32'h0000_0005));
    issue(make_req(OP_VADD, 2, 0, 1, 0));
    issue(make_req(OP_VSUB, 3, 1, 0, 0));
    issue(make_req(OP_VADDX, 4, 0, 0, 32'h0000_0010));
    issue(make_req(OP_VEXT, 0, 2, 0, 3));
    issue(make_req(OP_VREDSUM, 0, 3, 0, 0));
    issue(make_req(OP_VEXT, 0, 4, 0, 9));

    // Random arithmetic with readback
    for (int n = 0; n < N_RAND; n++) begin
      a = vreg_idx_t'(rand_bits(3));
      issue(make_req(pick_arith_op(rand_bits(3)), a, vreg_idx_t'(rand_bits(3)),
                     vreg_idx_t'(rand_bits(3)), rand_bits(32)));
      if (rand_bits(1)) begin
        issue(make_req(OP_VEXT, 0, a, 0, rand_bits(4)));
      end else begin
        issue(make_req(OP_VREDSUM, 0, a, 0, 0));
      end
    end

    // Reductions of fresh random vectors
    for (int n = 0; n < N_RED; n++) begin
      a = vreg_idx_t'(rand_bits(3));
      issue(make_req(OP_VMVX, a, 0, 0, rand_bits(32)));
      issue(make_req(OP_VREDSUM, 0, a, 0, 0));
    end

    // Requests while busy must leave no trace
    for (int n = 0; n < N_BUSY; n++) begin
      a = vreg_idx_t'(rand_bits(3));
      b = vreg_idx_t'(rand_bits(3));
      v = rand_bits(32);
      issue(make_req(OP_VMVX, a, 0, 0, v), 1'b1, make_req(OP_VMVX, b, 0, 0, ~v));
      issue(make_req(OP_VREDSUM, 0, a, 0, 0), 1'b1, make_req(OP_VEXT, 0, b, 0, 3));
      issue(make_req(OP_VEXT, 0, b, 0, rand_bits(4)));
    end

    repeat (4) @(negedge clk);
    assert (exp_q.size() == 0) else begin
      protocol_errs++;
      $display("%0d expected responses never arrived", exp_q.size());
    end
    total = mismatch_errs + timing_errs + protocol_errs
          + i_vecu_top.i_dispatcher.i_assertions.fail_cnt;
    $display("Errors: mismatch %0d, timing %0d, protocol %0d, assertion %0d", mismatch_errs,
             timing_errs, protocol_errs, i_vecu_top.i_dispatcher.i_assertions.fail_cnt);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : vecu_tb

/* vecu.f */
+incdir+source
source/vecu_pkg.sv
source/vecu_dispatcher.sv
source/vecu_sequencer.sv
source/vecu_lane.sv
source/vecu_reduction_unit.sv
source/vecu_top.sv
bench/vecu_tb_clock.sv
bench/vecu_assertions.sv
bench/vecu_tb.sv
